// ==== logic/aluPkg.sv ====
package aluPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        opAdd = 3'd0,  // x + y
        opSub = 3'd1,  // x - y
        opNot = 3'd2,  // ~x
        opAnd = 3'd3,
        opOr  = 3'd4,
        opXor = 3'd5,
        opSlt = 3'd6,  // Signed x < y, one bit
        opSeq = 3'd7   // x == y, one bit
    } aluOpT;

    ////////////////////////////////////////////////////////////////////////////
    // Default sizes
    ////////////////////////////////////////////////////////////////////////////

    // Operand width of the datapath
    localparam int dataWidthDef = 4;

    localparam int regCountDef = 4;  // Operand registers in the core

endpackage

// ==== logic/adder.sv ====
module adder #(
    parameter int dataWidth = aluPkg::dataWidthDef
) (
    input  logic                 cin,
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    output logic [dataWidth-1:0] sum,
    output logic                 carry,
    output logic                 zero,
    output logic                 overflow
);

    logic [dataWidth:0] chain;  // Carry into each bit position

    assign chain[0] = cin;

    // One full adder per bit with the carry rippling upward
    for (genvar i = 0; i < dataWidth; i++) begin : gBit
        assign sum[i]     = a[i] ^ b[i] ^ chain[i];
        assign chain[i+1] = (a[i] & b[i]) | (chain[i] & (a[i] ^ b[i]));
    end

    assign carry = chain[dataWidth];
    assign zero  = ~|sum;

    // Operands agree in sign but the sum does not
    assign overflow = (a[dataWidth-1] == b[dataWidth-1]) &&
                      (sum[dataWidth-1] != a[dataWidth-1]);

endmodule

// ==== logic/alu.sv ====
module alu #(
    parameter int dataWidth = aluPkg::dataWidthDef
) (
    input  aluPkg::aluOpT        op,
    input  logic [dataWidth-1:0] x,
    input  logic [dataWidth-1:0] y,
    output logic [dataWidth-1:0] result,
    output logic                 carry,
    output logic                 zero,
    output logic                 overflow
);

    import aluPkg::*;

    logic                 addCin;
    logic [dataWidth-1:0] addA;
    logic [dataWidth-1:0] addB;
    logic [dataWidth-1:0] addSum;
    logic                 addCarry;
    logic                 addZero;
    logic                 addOverflow;

    adder #(
        .dataWidth(dataWidth)
    ) u_adder (
        .cin     (addCin),
        .a       (addA),
        .b       (addB),
        .sum     (addSum),
        .carry   (addCarry),
        .zero    (addZero),
        .overflow(addOverflow)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Operand steering
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        addCin = 1'b0;
        addA   = x;
        addB   = y;
        case (op)
            opSub, opSlt, opSeq: begin  // Two's complement subtract
                addCin = 1'b1;
                addB   = ~y;
            end
            opNot: begin
                addA = ~x;
                addB = '0;
            end
            opAnd: begin
                addA = x & y;
                addB = '0;
            end
            opOr: begin
                addA = x | y;
                addB = '0;
            end
            opXor: begin
                addA = x ^ y;
                addB = '0;
            end
            default: addB = y;  // Add
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Result and flags
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        result   = addSum;
        carry    = addCarry;
        zero     = addZero;
        overflow = addOverflow;
        case (op)
            opNot, opAnd, opOr, opXor: begin
                carry    = 1'b0;
                overflow = 1'b0;
            end
            opSlt: begin
                result    = '0;
                result[0] = addSum[dataWidth-1] ^ addOverflow;  // True sign of x - y
            end
            opSeq: begin
                result    = '0;
                result[0] = addZero;
            end
            default: result = addSum;
        endcase
    end

    // Equality must come out of the subtraction through the adder
    always_comb begin
        if (op == opSeq) begin
            assert final (result[0] == (x == y) && zero == (x == y))
                else $error("Seq result disagrees with operand equality");
        end
    end

endmodule

// ==== logic/regFile.sv ====
module regFile #(
    parameter int dataWidth = aluPkg::dataWidthDef,
    parameter int regCount  = aluPkg::regCountDef,
    localparam int addrWidth = (regCount > 1) ? $clog2(regCount) : 1
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 wrEn,
    input  logic [addrWidth-1:0] wrAddr,
    input  logic [dataWidth-1:0] wrData,
    input  logic                 wbEn,
    input  logic [addrWidth-1:0] wbAddr,
    input  logic [dataWidth-1:0] wbData,
    input  logic [addrWidth-1:0] rdAddrX,
    input  logic [addrWidth-1:0] rdAddrY,
    output logic [dataWidth-1:0] rdDataX,
    output logic [dataWidth-1:0] rdDataY
);

    logic [dataWidth-1:0] regs [regCount];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wrEn) begin
                regs[wrAddr] <= wrData;
            end
            // Writeback comes last so it wins on an address clash
            if (wbEn) begin
                regs[wbAddr] <= wbData;
            end
        end
    end

    assign rdDataX = regs[rdAddrX];  // Read ports see the old value until the edge
    assign rdDataY = regs[rdAddrY];

    // Address space may be larger than the bank when regCount is not a power of two
    assert property (@(posedge clk) disable iff (!rstN) wrEn |-> wrAddr < regCount)
        else $error("External write to missing register %0d", wrAddr);

    assert property (@(posedge clk) disable iff (!rstN) wbEn |-> wbAddr < regCount)
        else $error("Writeback to missing register %0d", wbAddr);

endmodule

// ==== logic/resultStage.sv ====
module resultStage #(
    parameter int dataWidth = aluPkg::dataWidthDef
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 exec,
    input  logic [dataWidth-1:0] aluResult,
    input  logic                 aluCarry,
    input  logic                 aluZero,
    input  logic                 aluOverflow,
    output logic [dataWidth-1:0] result,
    output logic                 carry,
    output logic                 zero,
    output logic                 overflow,
    output logic                 done
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            result   <= '0;
            carry    <= 1'b0;
            zero     <= 1'b0;
            overflow <= 1'b0;
        end else if (exec) begin  // Held until the next execute
            result   <= aluResult;
            carry    <= aluCarry;
            zero     <= aluZero;
            overflow <= aluOverflow;
        end
    end

    // Done pulses once per execute and lines up with the captured result
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            done <= 1'b0;
        end else begin
            done <= exec;
        end
    end

endmodule

// ==== logic/aluCore.sv ====
module aluCore #(
    parameter int dataWidth = aluPkg::dataWidthDef,
    parameter int regCount  = aluPkg::regCountDef,
    localparam int addrWidth = (regCount > 1) ? $clog2(regCount) : 1
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 wrEn,
    input  logic [addrWidth-1:0] wrAddr,
    input  logic [dataWidth-1:0] wrData,
    input  logic                 exec,
    input  aluPkg::aluOpT        op,
    input  logic [addrWidth-1:0] srcX,
    input  logic [addrWidth-1:0] srcY,
    input  logic [addrWidth-1:0] dstAddr,
    output logic [dataWidth-1:0] result,
    output logic                 carry,
    output logic                 zero,
    output logic                 overflow,
    output logic                 done
);

    logic [dataWidth-1:0] operandX;
    logic [dataWidth-1:0] operandY;
    logic [dataWidth-1:0] aluResult;
    logic                 aluCarry;
    logic                 aluZero;
    logic                 aluOverflow;

    // Result is written back into dstAddr on the execute edge
    regFile #(
        .dataWidth(dataWidth),
        .regCount (regCount)
    ) u_regFile (
        .clk    (clk),
        .rstN   (rstN),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .wbEn   (exec),
        .wbAddr (dstAddr),
        .wbData (aluResult),
        .rdAddrX(srcX),
        .rdAddrY(srcY),
        .rdDataX(operandX),
        .rdDataY(operandY)
    );

    alu #(
        .dataWidth(dataWidth)
    ) u_alu (
        .op      (op),
        .x       (operandX),
        .y       (operandY),
        .result  (aluResult),
        .carry   (aluCarry),
        .zero    (aluZero),
        .overflow(aluOverflow)
    );

    resultStage #(
        .dataWidth(dataWidth)
    ) u_resultStage (
        .clk        (clk),
        .rstN       (rstN),
        .exec       (exec),
        .aluResult  (aluResult),
        .aluCarry   (aluCarry),
        .aluZero    (aluZero),
        .aluOverflow(aluOverflow),
        .result     (result),
        .carry      (carry),
        .zero       (zero),
        .overflow   (overflow),
        .done       (done)
    );

endmodule

// ==== verif/aluCoreTb.sv ====
module aluCoreTb;

    timeunit 1ns;
    timeprecision 100ps;

    import aluPkg::*;

    // About 800 cycles of random arithmetic, 240 of logic and some 100 more
    localparam int maxCycles = 2000;

    logic       clk;
    logic       rstN;
    logic       wrEn;
    logic [1:0] wrAddr;
    logic [3:0] wrData;
    logic       exec;
    aluOpT      op;
    logic [1:0] srcX;
    logic [1:0] srcY;
    logic [1:0] dstAddr;
    logic [3:0] result;
    logic       carry;
    logic       zero;
    logic       overflow;
    logic       done;

    logic [3:0] shadow [4];  // Register contents the DUT should hold
    int         errors = 0;
    int         cycles = 0;
    int         seed = 32'hb856;

    aluCore u_dut (
        .clk(clk), .rstN(rstN), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .exec(exec), .op(op), .srcX(srcX), .srcY(srcY), .dstAddr(dstAddr),
        .result(result), .carry(carry), .zero(zero), .overflow(overflow), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > maxCycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", maxCycles);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checking and reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic compareValue(input string name, input logic [3:0] exp, input logic [3:0] got);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic compareBit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    // Flags follow the arithmetic meaning of signed values in -8..7
    task automatic computeExpected(input aluOpT opSel, input logic [3:0] x, input logic [3:0] y,
                                   output logic [3:0] res, output logic c, output logic z,
                                   output logic v);
        int sx;
        int sy;
        logic [3:0] diffRes;
        logic diffC;
        logic diffV;
        sx = x[3] ? int'(x) - 16 : int'(x);
        sy = y[3] ? int'(y) - 16 : int'(y);
        diffRes = x - y;
        diffC = (x >= y);  // No borrow
        diffV = (sx - sy < -8) || (sx - sy > 7);
        c = 1'b0;
        v = 1'b0;
        case (opSel)
            opAdd: begin
                res = x + y;
                c = (int'(x) + int'(y) > 15);
                v = (sx + sy < -8) || (sx + sy > 7);
            end
            opSub: begin
                res = diffRes;
                c = diffC;
                v = diffV;
            end
            opNot: res = ~x;
            opAnd: res = x & y;
            opOr:  res = x | y;
            opXor: res = x ^ y;
            opSlt: res = {3'b000, sx < sy};
            default: res = {3'b000, x == y};
        endcase
        z = (res == 4'd0);
        if (opSlt == opSel || opSeq == opSel) begin  // Flags come from the subtraction
            c = diffC;
            z = (diffRes == 4'd0);
            v = diffV;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Drivers
    ////////////////////////////////////////////////////////////////////////////

    task automatic writeReg(input logic [1:0] addr, input logic [3:0] data);
        exec = 1'b0;
        wrEn = 1'b1;
        wrAddr = addr;
        wrData = data;
        @(posedge clk);
        #2;
        wrEn = 1'b0;
        shadow[addr] = data;
    endtask

    // Leaves exec high so that a following call runs back to back
    task automatic runOp(input aluOpT opSel, input logic [1:0] xAddr, input logic [1:0] yAddr,
                         input logic [1:0] dst);
        logic [3:0] expRes;
        logic expC;
        logic expZ;
        logic expV;
        computeExpected(opSel, shadow[xAddr], shadow[yAddr], expRes, expC, expZ, expV);
        exec = 1'b1;
        op = opSel;
        srcX = xAddr;
        srcY = yAddr;
        dstAddr = dst;
        @(posedge clk);
        #2;
        shadow[dst] = expRes;
        compareBit("done", 1'b1, done);
        compareValue("result", expRes, result);
        compareBit("carry", expC, carry);
        compareBit("zero", expZ, zero);
        compareBit("overflow", expV, overflow);
    endtask

    task automatic idle();
        exec = 1'b0;
        @(posedge clk);
        #2;
        compareBit("done", 1'b0, done);  // The pulse lasts one cycle
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic resetTest();
        compareBit("done", 1'b0, done);
        compareValue("result", 4'd0, result);
        compareBit("carry", 1'b0, carry);
        compareBit("zero", 1'b0, zero);
        compareBit("overflow", 1'b0, overflow);
        runOp(opOr, 2'd0, 2'd0, 2'd0);
        idle();
    endtask

    task automatic arithPair(input logic [3:0] a, input logic [3:0] b);
        writeReg(2'd1, a);
        writeReg(2'd2, b);
        runOp(opAdd, 2'd1, 2'd2, 2'd3);
        runOp(opSub, 2'd1, 2'd2, 2'd3);
    endtask

    task automatic arithTest();
        int r;
        arithPair(4'd7, 4'd1);
        arithPair(4'd8, 4'd1);
        arithPair(4'd15, 4'd1);
        arithPair(4'd3, 4'd5);
        for (int i = 0; i < 200; i++) begin
            r = $random(seed);
            arithPair(r[3:0], r[7:4]);
        end
        idle();
    endtask

    task automatic logicTest();
        int r;
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            writeReg(2'd1, r[3:0]);
            writeReg(2'd2, r[7:4]);
            runOp(opNot, 2'd1, 2'd2, 2'd3);
            runOp(opAnd, 2'd1, 2'd2, 2'd3);
            runOp(opOr, 2'd1, 2'd2, 2'd3);
            runOp(opXor, 2'd1, 2'd2, 2'd3);
        end
        idle();
    endtask

    task automatic comparePair(input logic [3:0] a, input logic [3:0] b);
        writeReg(2'd1, a);
        writeReg(2'd2, b);
        runOp(opSlt, 2'd1, 2'd2, 2'd3);
        runOp(opSeq, 2'd1, 2'd2, 2'd3);
    endtask

    task automatic compareTest();
        comparePair(4'd8, 4'd7);   // -8 against 7
        comparePair(4'd7, 4'd8);
        comparePair(4'd5, 4'd5);
        comparePair(4'd0, 4'd0);
        comparePair(4'd3, 4'd4);
        comparePair(4'd4, 4'd3);
        comparePair(4'd15, 4'd0);  // -1 against 0
        comparePair(4'd0, 4'd15);
        comparePair(4'd8, 4'd9);
        idle();
    endtask

    task automatic writebackTest();
        logic [3:0] wbRes;
        logic c;
        logic z;
        logic v;
        writeReg(2'd0, 4'd3);
        writeReg(2'd1, 4'd5);
        // Each step reads the register written one cycle earlier
        runOp(opAdd, 2'd0, 2'd1, 2'd2);
        runOp(opAdd, 2'd2, 2'd1, 2'd3);
        runOp(opSub, 2'd3, 2'd2, 2'd0);
        runOp(opXor, 2'd0, 2'd3, 2'd1);
        idle();
        computeExpected(opAdd, shadow[0], shadow[1], wbRes, c, z, v);
        wrEn = 1'b1;
        wrAddr = 2'd2;
        wrData = ~wbRes;
        runOp(opAdd, 2'd0, 2'd1, 2'd2);
        wrEn = 1'b0;
        runOp(opOr, 2'd2, 2'd2, 2'd3);
        if (result !== wbRes) begin
            errors++;
            $display("Register 2 kept the external write instead of the writeback");
        end
        idle();
    endtask

    initial begin
        rstN = 1'b0;
        wrEn = 1'b0;
        wrAddr = 2'd0;
        wrData = 4'd0;
        exec = 1'b0;
        op = opAdd;
        srcX = 2'd0;
        srcY = 2'd0;
        dstAddr = 2'd0;
        for (int i = 0; i < 4; i++) begin
            shadow[i] = 4'd0;
        end
        repeat (3) @(posedge clk);
        #2;
        rstN = 1'b1;
        resetTest();
        arithTest();
        logicTest();
        compareTest();
        writebackTest();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== aluCore.f ====
logic/aluPkg.sv
logic/adder.sv
logic/alu.sv
logic/regFile.sv
logic/resultStage.sv
logic/aluCore.sv
verif/aluCoreTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = aluCoreTb
FILELIST = aluCore.f
BUILDDIR = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	@out="$$(./$(BUILDDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILDDIR)
